// ==== hw/mem_map_defs.svh ====
`ifndef MEM_MAP_DEFS_SVH
`define MEM_MAP_DEFS_SVH

// bus and DRAM widths
`define WORD_WIDTH       16
`define DRAM_ADDR_WIDTH  25

// CPU address map
`define DRAM_LAST            16'hF7FF
`define LED_FIRST            16'hF800
`define LED_LAST             16'hF809
`define UART_TX_READY_ADDR   16'hF80A
`define UART_TX_BYTE_ADDR    16'hF80B
`define VGA_WRITE_ADDR       16'hF80C

// frame buffer region in DRAM word addresses
`define FRAME_BASE       25'h0080000

// one VGA burst is one group of 32 pixels
`define BURST_LEN        32
// DRAM model cycles from request to ready
`define DRAM_LATENCY     4

// short bit time so a frame fits a short simulation
`define UART_CLKS_PER_BIT 8

`endif

// ==== hw/mem_map_pkg.sv ====
`include "mem_map_defs.svh"

package mem_map_pkg;

    typedef logic [`WORD_WIDTH-1:0]      word_t;
    typedef logic [`DRAM_ADDR_WIDTH-1:0] dram_addr_t;

    // 4 bits each of blue, green, red
    typedef logic [11:0] bgr_t;

    typedef enum logic [2:0] {
        map_idle,
        map_fetch_instr,
        map_wait,
        map_instr_out,
        map_rw_data,
        map_data_out,
        map_fetch_vga
    } map_state_t;

    // pixel port takes x, then y, then the color
    typedef enum logic [1:0] {
        vga_wr_x,
        vga_wr_y,
        vga_wr_bgr
    } vga_wr_state_t;

    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

endpackage

// ==== hw/mem_map.sv ====
`timescale 1ns/1ps
`include "mem_map_defs.svh"

module mem_map (
    input  logic                                 clk,
    input  logic                                 rst,
    input  mem_map_pkg::word_t                   pc,
    input  mem_map_pkg::word_t                   data_addr,
    input  mem_map_pkg::word_t                   data_in,
    input  logic                                 write_en,
    input  logic                                 clk_stb_800k,
    input  logic                                 vga_en,
    input  logic [4:0]                           vga_x_group,
    input  logic [8:0]                           vga_y_val,
    input  mem_map_pkg::word_t                   dram_read_data,
    input  mem_map_pkg::word_t [`BURST_LEN-1:0]  dram_burst_buf,
    input  logic                                 dram_data_ready,
    input  logic                                 uart_tx_ready,
    output logic                                 dram_refresh_data,
    output mem_map_pkg::dram_addr_t              dram_addr,
    output logic                                 dram_write_en,
    output logic                                 dram_burst_en,
    output mem_map_pkg::word_t                   dram_data_in,
    output mem_map_pkg::word_t                   read_data,
    output mem_map_pkg::word_t                   instr,
    output logic [9:0]                           led,
    output logic [7:0]                           uart_tx_byte,
    output logic                                 uart_tx_start_n,
    output mem_map_pkg::bgr_t [`BURST_LEN-1:0]   vga_bgr_buf,
    output logic                                 mem_busy
);
    mem_map_pkg::map_state_t    state;
    mem_map_pkg::map_state_t    next_state;
    mem_map_pkg::vga_wr_state_t vga_wr_state;
    mem_map_pkg::dram_addr_t    pixel_addr;
    mem_map_pkg::dram_addr_t    burst_addr;
    logic                       got_instr;
    logic                       got_data;
    logic                       uart_ready_q;
    logic [9:0]                 vga_x_in;
    logic [8:0]                 vga_y_in;
    logic [3:0]                 led_idx;
    logic                       pc_in_dram;
    logic                       data_in_dram;
    logic                       data_is_led;

    always_comb begin
        for (int i = 0; i < `BURST_LEN; i++) begin
            vga_bgr_buf[i] = dram_burst_buf[i][11:0];
        end
    end

    assign pc_in_dram   = pc <= `DRAM_LAST;
    assign data_in_dram = data_addr <= `DRAM_LAST;
    assign data_is_led  = data_addr >= `LED_FIRST && data_addr <= `LED_LAST;
    assign led_idx      = 4'(data_addr - `LED_FIRST);

    // frame word address is base + (y << 10) + x
    assign pixel_addr = `FRAME_BASE + (mem_map_pkg::dram_addr_t'(vga_y_in) << 10)
                      + mem_map_pkg::dram_addr_t'(vga_x_in);
    assign burst_addr = `FRAME_BASE + (mem_map_pkg::dram_addr_t'(vga_y_val) << 10)
                      + mem_map_pkg::dram_addr_t'(vga_x_group)
                      * mem_map_pkg::dram_addr_t'(`BURST_LEN);

    // each issuing state lasts one cycle so the request is a strobe
    assign dram_refresh_data = state == mem_map_pkg::map_fetch_instr
                            || state == mem_map_pkg::map_rw_data
                            || state == mem_map_pkg::map_fetch_vga;
    assign mem_busy = state != mem_map_pkg::map_idle;

    always_comb begin
        next_state = state;
        case (state)
            mem_map_pkg::map_idle: begin
                if (clk_stb_800k) next_state = mem_map_pkg::map_fetch_instr;
            end
            mem_map_pkg::map_fetch_instr: next_state = mem_map_pkg::map_wait;
            mem_map_pkg::map_wait: begin
                if (dram_data_ready) begin
                    if (!got_instr) next_state = mem_map_pkg::map_instr_out;
                    else if (!got_data) next_state = mem_map_pkg::map_data_out;
                    else next_state = mem_map_pkg::map_idle;
                end
            end
            mem_map_pkg::map_instr_out: next_state = mem_map_pkg::map_rw_data;
            mem_map_pkg::map_rw_data: next_state = mem_map_pkg::map_wait;
            mem_map_pkg::map_data_out: begin
                if (vga_en) next_state = mem_map_pkg::map_fetch_vga;
                else next_state = mem_map_pkg::map_idle;
            end
            mem_map_pkg::map_fetch_vga: next_state = mem_map_pkg::map_wait;
            default: next_state = mem_map_pkg::map_idle;
        endcase
    end

    // outputs are loaded on the edge that enters a state
    always_ff @(posedge clk) begin
        if (!rst) begin
            state           <= mem_map_pkg::map_idle;
            got_instr       <= 1'b0;
            got_data        <= 1'b0;
            dram_write_en   <= 1'b0;
            dram_burst_en   <= 1'b0;
            led             <= '0;
            instr           <= '1;
            uart_tx_start_n <= 1'b1;
            uart_ready_q    <= 1'b1;
            vga_wr_state    <= mem_map_pkg::vga_wr_x;
        end else begin
            state        <= next_state;
            uart_ready_q <= uart_tx_ready;
            // release start once the frame is done
            if (uart_tx_ready && !uart_ready_q) uart_tx_start_n <= 1'b1;

            case (next_state)
                mem_map_pkg::map_fetch_instr: begin
                    dram_burst_en <= 1'b0;
                    dram_write_en <= 1'b0;
                    dram_addr     <= pc_in_dram ? mem_map_pkg::dram_addr_t'(pc) : '0;
                    got_instr     <= 1'b0;
                    got_data      <= 1'b0;
                end
                mem_map_pkg::map_instr_out: begin
                    instr     <= dram_read_data;
                    got_instr <= 1'b1;
                end
                mem_map_pkg::map_rw_data: begin
                    dram_data_in  <= data_in;
                    dram_addr     <= data_in_dram ? mem_map_pkg::dram_addr_t'(data_addr) : '0;
                    dram_write_en <= data_in_dram && write_en;
                    if (write_en && data_is_led) led[led_idx] <= data_in[0];
                    if (write_en && data_addr == `UART_TX_BYTE_ADDR) begin
                        uart_tx_byte    <= data_in[7:0];
                        uart_tx_start_n <= 1'b0;
                    end
                    if (write_en && data_addr == `VGA_WRITE_ADDR) begin
                        case (vga_wr_state)
                            mem_map_pkg::vga_wr_x: begin
                                vga_x_in     <= data_in[9:0];
                                vga_wr_state <= mem_map_pkg::vga_wr_y;
                            end
                            mem_map_pkg::vga_wr_y: begin
                                vga_y_in     <= data_in[8:0];
                                vga_wr_state <= mem_map_pkg::vga_wr_bgr;
                            end
                            default: begin
                                // third write goes to the frame region
                                dram_addr     <= pixel_addr;
                                dram_write_en <= 1'b1;
                                vga_wr_state  <= mem_map_pkg::vga_wr_x;
                            end
                        endcase
                    end
                end
                mem_map_pkg::map_data_out: begin
                    got_data <= 1'b1;
                    if (data_addr == `UART_TX_READY_ADDR)
                        read_data <= mem_map_pkg::word_t'(uart_tx_ready);
                    else
                        read_data <= dram_read_data;
                end
                mem_map_pkg::map_fetch_vga: begin
                    dram_burst_en <= 1'b1;
                    dram_write_en <= 1'b0;
                    dram_addr     <= burst_addr;
                end
                default: begin
                end
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        state <= mem_map_pkg::map_fetch_vga)
        else $error("mem_map state out of range: %0h", state);

    a_req_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        dram_refresh_data |=> !dram_refresh_data)
        else $error("dram_refresh_data held for two cycles");

endmodule

// ==== hw/dram_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_map_defs.svh"

module dram_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 dram_refresh_data,
    input  mem_map_pkg::dram_addr_t              dram_addr,
    input  logic                                 dram_write_en,
    input  logic                                 dram_burst_en,
    input  mem_map_pkg::word_t                   dram_data_in,
    output mem_map_pkg::word_t                   dram_read_data,
    output mem_map_pkg::word_t [`BURST_LEN-1:0]  dram_burst_buf,
    output logic                                 dram_data_ready
);
    localparam int PROG_AW  = 16;
    localparam int FRAME_AW = 19;
    localparam int CNT_W    = $clog2(`DRAM_LATENCY + `BURST_LEN);
    localparam int BEAT_W   = $clog2(`BURST_LEN);

    mem_map_pkg::word_t      prog_mem  [2**PROG_AW];
    mem_map_pkg::word_t      frame_mem [2**FRAME_AW];

    logic                    pending;
    logic [CNT_W-1:0]        cnt;
    mem_map_pkg::dram_addr_t req_addr;
    logic                    req_write;
    logic                    req_burst;
    mem_map_pkg::word_t      req_data;
    logic [BEAT_W-1:0]       beat;
    mem_map_pkg::dram_addr_t beat_addr;

    function automatic logic in_prog(input mem_map_pkg::dram_addr_t a);
        return a < mem_map_pkg::dram_addr_t'(2**PROG_AW);
    endfunction

    function automatic logic in_frame(input mem_map_pkg::dram_addr_t a);
        return a >= `FRAME_BASE && a < `FRAME_BASE + mem_map_pkg::dram_addr_t'(2**FRAME_AW);
    endfunction

    // unmapped addresses read as zero
    function automatic mem_map_pkg::word_t read_word(input mem_map_pkg::dram_addr_t a);
        if (in_prog(a)) return prog_mem[a[PROG_AW-1:0]];
        if (in_frame(a)) return frame_mem[a[FRAME_AW-1:0]];
        return '0;
    endfunction

    // burst beats fill the last BURST_LEN cycles before ready
    assign beat      = BEAT_W'(`BURST_LEN - 1 - cnt);
    assign beat_addr = req_addr + mem_map_pkg::dram_addr_t'(beat);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pending         <= 1'b0;
            cnt             <= '0;
            dram_data_ready <= 1'b0;
        end else begin
            dram_data_ready <= 1'b0;
            if (dram_refresh_data) begin
                pending   <= 1'b1;
                req_addr  <= dram_addr;
                req_write <= dram_write_en;
                req_burst <= dram_burst_en;
                req_data  <= dram_data_in;
                cnt <= dram_burst_en ? CNT_W'(`DRAM_LATENCY + `BURST_LEN - 2)
                                     : CNT_W'(`DRAM_LATENCY - 2);
            end else if (pending) begin
                if (req_burst && cnt < `BURST_LEN) dram_burst_buf[beat] <= read_word(beat_addr);
                if (cnt == '0) begin
                    pending         <= 1'b0;
                    dram_data_ready <= 1'b1;
                    if (req_write && !req_burst) begin
                        dram_read_data <= req_data;
                        if (in_prog(req_addr)) prog_mem[req_addr[PROG_AW-1:0]] <= req_data;
                        else if (in_frame(req_addr)) frame_mem[req_addr[FRAME_AW-1:0]] <= req_data;
                    end else if (!req_burst) begin
                        dram_read_data <= read_word(req_addr);
                    end
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
        dram_refresh_data |-> !pending)
        else $error("DRAM request while another is pending, addr %h", dram_addr);

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`include "mem_map_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] uart_tx_byte,
    input  logic       uart_tx_start_n,
    output logic       uart_txd,
    output logic       uart_tx_ready
);
    localparam int CLK_W = $clog2(`UART_CLKS_PER_BIT);

    mem_map_pkg::uart_state_t state;
    logic [CLK_W-1:0]         clk_cnt;
    logic [2:0]               bit_idx;
    logic [7:0]               shift;
    logic                     start_q;
    logic                     bit_end;

    assign bit_end = clk_cnt == CLK_W'(`UART_CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= mem_map_pkg::uart_idle;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            start_q       <= 1'b1;
            uart_txd      <= 1'b1;
            uart_tx_ready <= 1'b1;
        end else begin
            start_q <= uart_tx_start_n;
            if (state == mem_map_pkg::uart_idle) begin
                // falling edge of start_n begins a frame
                if (start_q && !uart_tx_start_n) begin
                    shift         <= uart_tx_byte;
                    clk_cnt       <= '0;
                    bit_idx       <= '0;
                    uart_txd      <= 1'b0;
                    uart_tx_ready <= 1'b0;
                    state         <= mem_map_pkg::uart_start;
                end
            end else if (!bit_end) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                case (state)
                    mem_map_pkg::uart_start: begin
                        uart_txd <= shift[0];
                        state    <= mem_map_pkg::uart_data;
                    end
                    mem_map_pkg::uart_data: begin
                        // lsb first
                        shift    <= shift >> 1;
                        bit_idx  <= bit_idx + 1'b1;
                        uart_txd <= (bit_idx == 3'd7) ? 1'b1 : shift[1];
                        if (bit_idx == 3'd7) state <= mem_map_pkg::uart_stop;
                    end
                    default: begin
                        uart_tx_ready <= 1'b1;
                        state         <= mem_map_pkg::uart_idle;
                    end
                endcase
            end
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst)
        state == mem_map_pkg::uart_idle |-> uart_txd)
        else $error("uart_txd low while idle");

endmodule

// ==== hw/mem_sys_top.sv ====
`timescale 1ns/1ps
`include "mem_map_defs.svh"

module mem_sys_top (
    input  logic                                clk,
    input  logic                                rst,
    input  mem_map_pkg::word_t                  pc,
    input  mem_map_pkg::word_t                  data_addr,
    input  mem_map_pkg::word_t                  data_in,
    input  logic                                write_en,
    input  logic                                clk_stb_800k,
    input  logic                                vga_en,
    input  logic [4:0]                          vga_x_group,
    input  logic [8:0]                          vga_y_val,
    output mem_map_pkg::word_t                  instr,
    output mem_map_pkg::word_t                  read_data,
    output logic [9:0]                          led,
    output logic                                uart_txd,
    output mem_map_pkg::bgr_t [`BURST_LEN-1:0]  vga_bgr_buf,
    output logic                                mem_busy
);
    logic                                dram_refresh_data;
    mem_map_pkg::dram_addr_t             dram_addr;
    logic                                dram_write_en;
    logic                                dram_burst_en;
    mem_map_pkg::word_t                  dram_data_in;
    mem_map_pkg::word_t                  dram_read_data;
    mem_map_pkg::word_t [`BURST_LEN-1:0] dram_burst_buf;
    logic                                dram_data_ready;
    logic [7:0]                          uart_tx_byte;
    logic                                uart_tx_start_n;
    logic                                uart_tx_ready;

    mem_map u_mem_map (
        .clk, .rst, .pc, .data_addr, .data_in, .write_en, .clk_stb_800k,
        .vga_en, .vga_x_group, .vga_y_val, .dram_read_data, .dram_burst_buf,
        .dram_data_ready, .uart_tx_ready, .dram_refresh_data, .dram_addr,
        .dram_write_en, .dram_burst_en, .dram_data_in, .read_data, .instr,
        .led, .uart_tx_byte, .uart_tx_start_n, .vga_bgr_buf, .mem_busy
    );

    dram_ctrl u_dram_ctrl (
        .clk, .rst, .dram_refresh_data, .dram_addr, .dram_write_en,
        .dram_burst_en, .dram_data_in, .dram_read_data, .dram_burst_buf,
        .dram_data_ready
    );

    uart_tx u_uart_tx (
        .clk, .rst, .uart_tx_byte, .uart_tx_start_n, .uart_txd, .uart_tx_ready
    );

endmodule

// ==== verif/mem_sys_tb.sv ====
`timescale 1ns/1ps
`include "mem_map_defs.svh"

module mem_sys_tb;

    localparam int STEP_TIMEOUT = 200;
    localparam int RX_TIMEOUT   = 20 * `UART_CLKS_PER_BIT;
    localparam int HALF_BIT     = `UART_CLKS_PER_BIT / 2;

    logic                               clk;
    logic                               rst;
    mem_map_pkg::word_t                 pc;
    mem_map_pkg::word_t                 data_addr;
    mem_map_pkg::word_t                 data_in;
    logic                               write_en;
    logic                               clk_stb_800k;
    logic                               vga_en;
    logic [4:0]                         vga_x_group;
    logic [8:0]                         vga_y_val;
    mem_map_pkg::word_t                 instr;
    mem_map_pkg::word_t                 read_data;
    logic [9:0]                         led;
    logic                               uart_txd;
    mem_map_pkg::bgr_t [`BURST_LEN-1:0] vga_bgr_buf;
    logic                               mem_busy;

    // serial line decoder
    logic       rx_busy;
    int         rx_tick;
    logic [7:0] rx_shift;
    logic [7:0] rx_bytes[$];

    integer            seed;
    logic [9:0]        led_model;
    mem_map_pkg::bgr_t colors [`BURST_LEN];

    mem_sys_top UUT (
        .clk, .rst, .pc, .data_addr, .data_in, .write_en, .clk_stb_800k,
        .vga_en, .vga_x_group, .vga_y_val, .instr, .read_data, .led,
        .uart_txd, .vga_bgr_buf, .mem_busy
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_word(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // pulse the strobe and hold the CPU inputs until the sequencer is idle again
    task automatic run_step(input mem_map_pkg::word_t pc_v, input mem_map_pkg::word_t addr_v,
                            input mem_map_pkg::word_t din_v, input logic we_v,
                            input logic vga_v);
        int n;
        @(posedge clk);
        #1;
        pc           = pc_v;
        data_addr    = addr_v;
        data_in      = din_v;
        write_en     = we_v;
        vga_en       = vga_v;
        clk_stb_800k = 1'b1;
        @(posedge clk);
        #1;
        clk_stb_800k = 1'b0;
        assert (mem_busy === 1'b1) else begin
            $display("bus step did not start after the strobe");
            stop_on_error();
        end
        n = 0;
        @(negedge clk);
        while (mem_busy !== 1'b0) begin
            n++;
            if (n > STEP_TIMEOUT) begin
                $display("Timeout: mem_busy did not fall within %0d cycles", STEP_TIMEOUT);
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input mem_map_pkg::word_t addr_v, input mem_map_pkg::word_t din_v);
        run_step(16'h0000, addr_v, din_v, 1'b1, 1'b0);
    endtask

    task automatic bus_read(input mem_map_pkg::word_t addr_v);
        run_step(16'h0000, addr_v, 16'h0000, 1'b0, 1'b0);
    endtask

    task automatic wait_rx_bytes(input int count);
        int n;
        n = 0;
        while (rx_bytes.size() < count) begin
            n++;
            if (n > RX_TIMEOUT) begin
                $display("Timeout: serial byte %0d never arrived on uart_txd", count);
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    // samples each bit in its middle and stores the byte when the frame ends
    // tick counts falling edges since the start bit was seen
    always @(negedge clk) begin
        if (rst !== 1'b1) begin
            rx_busy = 1'b0;
            rx_tick = 0;
        end else if (!rx_busy) begin
            if (uart_txd === 1'b0) begin
                rx_busy = 1'b1;
                rx_tick = 1;
            end
        end else begin
            if (rx_tick == HALF_BIT) begin
                assert (uart_txd === 1'b0) else begin
                    $display("start bit on uart_txd ended too early");
                    stop_on_error();
                end
            end else if (rx_tick == HALF_BIT + 9 * `UART_CLKS_PER_BIT) begin
                assert (uart_txd === 1'b1) else begin
                    $display("stop bit missing on uart_txd");
                    stop_on_error();
                end
            end else if (rx_tick == 10 * `UART_CLKS_PER_BIT) begin
                rx_bytes.push_back(rx_shift);
                rx_busy = 1'b0;
            end else if (rx_tick % `UART_CLKS_PER_BIT == HALF_BIT) begin
                rx_shift = {uart_txd, rx_shift[7:1]};
            end
            rx_tick = rx_tick + 1;
        end
    end

    // the LED register only moves inside a bus step
    a_led_in_step: assert property (@(posedge clk) disable iff (!rst)
        $changed(led) |-> mem_busy)
        else begin
            $display("led changed while no bus step was running");
            stop_on_error();
        end

    a_step_needs_stb: assert property (@(posedge clk) disable iff (!rst)
        $rose(mem_busy) |-> $past(clk_stb_800k))
        else begin
            $display("bus step started without a strobe");
            stop_on_error();
        end

    initial begin
        int          i;
        logic [31:0] rnd;
        logic [9:0]  pattern;
        seed         = 32'hc74b_0891;
        rst          = 1'b0;
        pc           = '0;
        data_addr    = '0;
        data_in      = '0;
        write_en     = 1'b0;
        clk_stb_800k = 1'b0;
        vga_en       = 1'b0;
        vga_x_group  = 5'd3;
        vga_y_val    = 9'd17;
        led_model    = '0;
        pattern      = 10'b10_1101_0110;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);

        expect_word("instr", instr, 16'hFFFF);
        expect_word("led", 16'(led), 16'h0000);
        expect_word("uart_txd", 16'(uart_txd), 16'h0001);
        expect_word("mem_busy", 16'(mem_busy), 16'h0000);

        // DRAM data path and instruction fetch
        bus_write(16'h0456, 16'h0123);
        bus_write(16'h0000, 16'hBEEF);
        bus_read(16'h0456);
        expect_word("read_data", read_data, 16'h0123);
        run_step(16'h0456, 16'h0000, 16'h0000, 1'b0, 1'b0);
        expect_word("instr", instr, 16'h0123);
        // pc outside DRAM fetches address 0
        run_step(16'hFA00, 16'h0000, 16'h0000, 1'b0, 1'b0);
        expect_word("instr", instr, 16'hBEEF);

        for (i = 0; i < 10; i++) begin
            bus_write(`LED_FIRST + 16'(i), {15'h2AAA, pattern[i]});
            led_model[i] = pattern[i];
            expect_word("led", 16'(led), 16'(led_model));
        end
        run_step(16'h0000, `LED_FIRST, {15'h0000, ~led_model[0]}, 1'b0, 1'b0);
        expect_word("led", 16'(led), 16'(led_model));
        bus_write(`LED_LAST, {15'h0000, ~led_model[9]});
        led_model[9] = ~led_model[9];
        expect_word("led", 16'(led), 16'(led_model));

        // UART byte, status poll and ordering
        bus_write(`UART_TX_BYTE_ADDR, 16'h00A5);
        bus_read(`UART_TX_READY_ADDR);
        expect_word("read_data", read_data, 16'h0000);
        wait_rx_bytes(1);
        bus_read(`UART_TX_READY_ADDR);
        expect_word("read_data", read_data, 16'h0001);
        bus_write(`UART_TX_BYTE_ADDR, 16'hFF3C);
        wait_rx_bytes(2);
        expect_word("uart_txd byte 0", 16'(rx_bytes[0]), 16'h00A5);
        expect_word("uart_txd byte 1", 16'(rx_bytes[1]), 16'h003C);

        // three writes per pixel and then one burst of the same group
        for (i = 0; i < `BURST_LEN; i++) begin
            rnd       = $random(seed);
            colors[i] = rnd[11:0];
            bus_write(`VGA_WRITE_ADDR, 16'(vga_x_group) * 16'(`BURST_LEN) + 16'(i));
            bus_write(`VGA_WRITE_ADDR, 16'(vga_y_val));
            bus_write(`VGA_WRITE_ADDR, {4'h0, colors[i]});
        end
        run_step(16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b1);
        for (i = 0; i < `BURST_LEN; i++) begin
            expect_word($sformatf("vga_bgr_buf[%0d]", i), 16'(vga_bgr_buf[i]),
                        16'(colors[i]));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/mem_map_pkg.sv
hw/mem_map.sv
hw/dram_ctrl.sv
hw/uart_tx.sv
hw/mem_sys_top.sv
verif/mem_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module mem_sys_tb -Mdir "$BUILD_DIR" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/Vmem_sys_tb" > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
    echo "simulation failed, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status, see $SIM_LOG"
    exit 1
fi

echo "simulation passed"
exit 0
